// File: rtl/afifo_pkg.sv
package afifo_pkg;

    // **********************************************************************
    // sizing
    // **********************************************************************

    // one entry and the address span of the storage
    localparam int DATA_WIDTH = 8;
    localparam int PTR_WIDTH  = 4;
    localparam int DEPTH      = 1 << PTR_WIDTH;

    // fixed flag thresholds, distance from the full and empty ends
    localparam int ALMOST_FULL_OFFSET  = 2;
    localparam int ALMOST_EMPTY_OFFSET = 2;

    // **********************************************************************
    // types
    // **********************************************************************

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [PTR_WIDTH-1:0]  addr_t;

    // extra msb is the wrap bit, same width for binary and gray form
    typedef logic [PTR_WIDTH:0]    ptr_t;

    // 0 .. DEPTH, so a full fifo reads DEPTH and not 0
    typedef logic [PTR_WIDTH:0]    fill_t;

    // write side status, all fields registered on i_wclk
    typedef struct packed {
        logic  full;
        logic  almost_full;
        fill_t fill;
    } wr_status_t;

    // read side status, all fields registered on i_rclk
    typedef struct packed {
        logic  empty;
        logic  almost_empty;
        fill_t fill;
    } rd_status_t;

    // **********************************************************************
    // gray conversion
    // **********************************************************************

    function automatic ptr_t bin_to_gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // msb passes through, each lower bit folds in the bits above it
    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_WIDTH] = gray[PTR_WIDTH];
        for (int i = PTR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: rtl/afifo_mem.sv
`timescale 1ns/1ns

module afifo_mem (
    input  logic              i_wclk,
    input  logic              i_we,
    input  afifo_pkg::addr_t  i_waddr,
    input  afifo_pkg::data_t  i_wdata,
    input  afifo_pkg::addr_t  i_raddr,
    output afifo_pkg::data_t  o_rdata
);

    import afifo_pkg::*;

    // storage array that maps to distributed ram
    data_t mem [DEPTH];

    // **********************************************************************
    // write port
    // **********************************************************************

    // i_we already carries the full qualification from the write controller
    always_ff @(posedge i_wclk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // **********************************************************************
    // read port
    // **********************************************************************

    // unregistered read where data follows i_raddr in the same cycle
    // the read domain samples it only while the fifo is not empty
    assign o_rdata = mem[i_raddr];

endmodule

// File: rtl/afifo_wr_ctrl.sv
`timescale 1ns/1ns

module afifo_wr_ctrl (
    input  logic                   i_wclk,
    input  logic                   i_wrstn,
    input  logic                   i_wvalid,
    input  afifo_pkg::ptr_t        i_rgray,
    output logic                   o_we,
    output afifo_pkg::addr_t       o_waddr,
    output afifo_pkg::ptr_t        o_wgray,
    output afifo_pkg::wr_status_t  o_wstatus
);

    import afifo_pkg::*;

    // binary write pointer, current and next
    ptr_t  wbin;
    ptr_t  wbin_next;

    // gray form of the next pointer, registered into o_wgray
    ptr_t  wgray_next;

    // read pointer brought over from the read domain
    ptr_t  wq1_rgray;
    ptr_t  wq2_rgray;
    ptr_t  wq2_rbin;

    // read pointer as it looks when the write side is one lap ahead
    ptr_t  full_gray;

    // next values of the status fields
    fill_t wfill_next;
    logic  wfull_next;
    logic  walmost_full_next;

    // **********************************************************************
    // read pointer synchronizer
    // **********************************************************************

    // two flops, the gray code keeps a sampled value within one step
    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wq1_rgray <= '0;
            wq2_rgray <= '0;
        end else begin
            wq1_rgray <= i_rgray;
            wq2_rgray <= wq1_rgray;
        end
    end

    // binary copy for the fill arithmetic
    assign wq2_rbin = gray_to_bin(wq2_rgray);

    // **********************************************************************
    // write pointer
    // **********************************************************************

    // accept only while not full, a blocked write is simply held by the source
    assign o_we       = i_wvalid && !o_wstatus.full;
    assign wbin_next  = wbin + ptr_t'(o_we);
    assign wgray_next = bin_to_gray(wbin_next);

    // memory address drops the wrap bit
    assign o_waddr    = wbin[PTR_WIDTH-1:0];

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wbin    <= '0;
            o_wgray <= '0;
        end else begin
            wbin    <= wbin_next;
            o_wgray <= wgray_next;
        end
    end

    // **********************************************************************
    // full, almost full and fill level
    // **********************************************************************

    // full when the writer is exactly one lap ahead
    // in gray form that means the two top bits differ, the rest match
    assign full_gray  = {~wq2_rgray[PTR_WIDTH:PTR_WIDTH-1], wq2_rgray[PTR_WIDTH-2:0]};
    assign wfull_next = (wgray_next == full_gray);

    // modulo difference of the wrap pointers, 0 .. DEPTH
    assign wfill_next = fill_t'(wbin_next - wq2_rbin);

    // almost full from the same next fill, so it moves with full
    assign walmost_full_next = (wfill_next >= fill_t'(DEPTH - ALMOST_FULL_OFFSET));

    // pessimistic flags: set on the accepting edge, cleared only once
    // the read pointer has crossed the synchronizer
    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            o_wstatus.full        <= 1'b0;
            o_wstatus.almost_full <= 1'b0;
            o_wstatus.fill        <= '0;
        end else begin
            o_wstatus.full        <= wfull_next;
            o_wstatus.almost_full <= walmost_full_next;
            o_wstatus.fill        <= wfill_next;
        end
    end

endmodule

// File: rtl/afifo_rd_ctrl.sv
`timescale 1ns/1ns

module afifo_rd_ctrl (
    input  logic                   i_rclk,
    input  logic                   i_rrstn,
    input  logic                   i_rready,
    input  afifo_pkg::ptr_t        i_wgray,
    output afifo_pkg::addr_t       o_raddr,
    output afifo_pkg::ptr_t        o_rgray,
    output afifo_pkg::rd_status_t  o_rstatus
);

    import afifo_pkg::*;

    // binary read pointer, current and next
    ptr_t  rbin;
    ptr_t  rbin_next;

    // gray form of the next pointer, registered into o_rgray
    ptr_t  rgray_next;

    // write pointer brought over from the write domain
    ptr_t  rq1_wgray;
    ptr_t  rq2_wgray;
    ptr_t  rq2_wbin;

    // a read is taken this cycle
    logic  rd_take;

    // next values of the status fields
    fill_t rfill_next;
    logic  rempty_next;
    logic  ralmost_empty_next;

    // **********************************************************************
    // write pointer synchronizer
    // **********************************************************************

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rq1_wgray <= '0;
            rq2_wgray <= '0;
        end else begin
            rq1_wgray <= i_wgray;
            rq2_wgray <= rq1_wgray;
        end
    end

    // binary copy for the fill arithmetic
    assign rq2_wbin = gray_to_bin(rq2_wgray);

    // **********************************************************************
    // read pointer
    // **********************************************************************

    // pop only while something is visible to this side
    assign rd_take    = i_rready && !o_rstatus.empty;
    assign rbin_next  = rbin + ptr_t'(rd_take);
    assign rgray_next = bin_to_gray(rbin_next);

    // current entry sits at rbin, so the memory output is the head
    assign o_raddr    = rbin[PTR_WIDTH-1:0];

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rbin    <= '0;
            o_rgray <= '0;
        end else begin
            rbin    <= rbin_next;
            o_rgray <= rgray_next;
        end
    end

    // **********************************************************************
    // empty, almost empty and fill level
    // **********************************************************************

    // empty when both gray pointers match, wrap bit included
    assign rempty_next = (rgray_next == rq2_wgray);

    // entries still readable after this edge
    assign rfill_next = fill_t'(rq2_wbin - rbin_next);

    assign ralmost_empty_next = (rfill_next <= fill_t'(ALMOST_EMPTY_OFFSET));

    // empty asserts on the edge of the last pop
    // it clears only after a new write has passed both flops
    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            o_rstatus.empty        <= 1'b1;
            o_rstatus.almost_empty <= 1'b1;
            o_rstatus.fill         <= '0;
        end else begin
            o_rstatus.empty        <= rempty_next;
            o_rstatus.almost_empty <= ralmost_empty_next;
            o_rstatus.fill         <= rfill_next;
        end
    end

endmodule

// File: rtl/afifo.sv
`timescale 1ns/1ns

module afifo (
    // write domain
    input  logic                   i_wclk,
    input  logic                   i_wrstn,
    input  logic                   i_wvalid,
    input  afifo_pkg::data_t       i_wdata,
    output logic                   o_wready,
    output afifo_pkg::wr_status_t  o_wstatus,

    // read domain
    input  logic                   i_rclk,
    input  logic                   i_rrstn,
    input  logic                   i_rready,
    output logic                   o_rvalid,
    output afifo_pkg::data_t       o_rdata,
    output afifo_pkg::rd_status_t  o_rstatus
);

    import afifo_pkg::*;

    // memory control from the two sides
    logic  we;
    addr_t waddr;
    addr_t raddr;

    // gray pointers crossing between the domains
    ptr_t  wgray;
    ptr_t  rgray;

    // **********************************************************************
    // handshake
    // **********************************************************************

    // ready and valid come straight from the registered flags
    assign o_wready = !o_wstatus.full;
    assign o_rvalid = !o_rstatus.empty;

    // **********************************************************************
    // storage and controllers
    // **********************************************************************

    afifo_mem u_mem (
        .i_wclk  (i_wclk),
        .i_we    (we),
        .i_waddr (waddr),
        .i_wdata (i_wdata),
        .i_raddr (raddr),
        .o_rdata (o_rdata)
    );

    afifo_wr_ctrl u_wr_ctrl (
        .i_wclk    (i_wclk),
        .i_wrstn   (i_wrstn),
        .i_wvalid  (i_wvalid),
        .i_rgray   (rgray),
        .o_we      (we),
        .o_waddr   (waddr),
        .o_wgray   (wgray),
        .o_wstatus (o_wstatus)
    );

    afifo_rd_ctrl u_rd_ctrl (
        .i_rclk    (i_rclk),
        .i_rrstn   (i_rrstn),
        .i_rready  (i_rready),
        .i_wgray   (wgray),
        .o_raddr   (raddr),
        .o_rgray   (rgray),
        .o_rstatus (o_rstatus)
    );

endmodule

// File: test/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int HALF_PERIOD = 50
) (
    output logic o_clk
);

    // free running, low for the first half period
    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

// File: test/afifo_asserts.sv
`timescale 1ns/1ns

module afifo_asserts (
    input logic                   i_wclk,
    input logic                   i_wrstn,
    input logic                   i_rclk,
    input logic                   i_rrstn,
    input afifo_pkg::ptr_t        i_wgray,
    input afifo_pkg::ptr_t        i_rgray,
    input afifo_pkg::wr_status_t  i_wstatus,
    input afifo_pkg::rd_status_t  i_rstatus
);

    // **********************************************************************
    // gray pointers crossing the domains
    // **********************************************************************

    // a synchronizer may only ever catch one bit in flight
    a_wgray_step: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        $countones(i_wgray ^ $past(i_wgray)) <= 1)
        else $error("write gray pointer moved by more than one bit");

    a_rgray_step: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        $countones(i_rgray ^ $past(i_rgray)) <= 1)
        else $error("read gray pointer moved by more than one bit");

    // **********************************************************************
    // no transfer past the flags
    // **********************************************************************

    // an edge seen with full high must leave the write pointer where it was
    a_no_write_full: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        i_wstatus.full |=> $stable(i_wgray))
        else $error("write pointer advanced while full was high");

    // same on the read side with empty
    a_no_read_empty: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        i_rstatus.empty |=> $stable(i_rgray))
        else $error("read pointer advanced while empty was high");

endmodule

bind afifo afifo_asserts u_asserts (
    .i_wclk    (i_wclk),
    .i_wrstn   (i_wrstn),
    .i_rclk    (i_rclk),
    .i_rrstn   (i_rrstn),
    .i_wgray   (wgray),
    .i_rgray   (rgray),
    .i_wstatus (o_wstatus),
    .i_rstatus (o_rstatus)
);

// File: test/tb_afifo_checker.sv
`timescale 1ns/1ns

module tb_afifo_checker (
    input  logic                   i_wclk,
    input  logic                   i_wrstn,
    input  logic                   i_wvalid,
    input  afifo_pkg::data_t       i_wdata,
    input  logic                   i_wready,
    input  afifo_pkg::wr_status_t  i_wstatus,
    input  logic                   i_rclk,
    input  logic                   i_rrstn,
    input  logic                   i_rready,
    input  logic                   i_rvalid,
    input  afifo_pkg::data_t       i_rdata,
    input  afifo_pkg::rd_status_t  i_rstatus,
    input  logic                   i_fill_check,
    input  int                     i_fill_expect,
    output int                     o_wr_errors,
    output int                     o_rd_errors
);

    import afifo_pkg::*;

    // every accepted write, in order; the read side walks it with r_count
    data_t sent[$];
    int    r_count = 0;

    // error counts, one per clock domain
    int    w_errors = 0;
    int    r_errors = 0;

    // first edge after a reset release still shows the reset values
    logic  w_was_reset = 1'b0;
    logic  r_was_reset = 1'b0;

    int    w_fill;
    int    r_fill;

    assign o_wr_errors = w_errors;
    assign o_rd_errors = r_errors;

    function automatic int report_mismatch(input string name, input int expected,
                                           input int actual);
        if (expected != actual) begin
            $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // **********************************************************************
    // write domain
    // **********************************************************************

    always @(posedge i_wclk) begin
        w_fill = int'(i_wstatus.fill);
        if (!i_wrstn || w_was_reset) begin
            w_errors += report_mismatch("o_wready", 1, int'(i_wready));
            w_errors += report_mismatch("o_wstatus.almost_full", 0, int'(i_wstatus.almost_full));
            w_errors += report_mismatch("o_wstatus.fill", 0, w_fill);
        end
        w_was_reset = !i_wrstn;
        // flags must agree with the registered fill level
        w_errors += report_mismatch("o_wstatus.full", int'(w_fill == DEPTH),
                                    int'(i_wstatus.full));
        w_errors += report_mismatch("o_wstatus.almost_full",
                                    int'(w_fill >= DEPTH - ALMOST_FULL_OFFSET),
                                    int'(i_wstatus.almost_full));
        w_errors += report_mismatch("o_wready", int'(!i_wstatus.full), int'(i_wready));
        if (i_wrstn && i_wvalid && i_wready) begin
            sent.push_back(i_wdata);
            if (sent.size() - r_count > DEPTH) begin
                $display("writes ran %0d entries ahead of reads at %0t ns, more than the depth",
                         sent.size() - r_count, $time);
                w_errors++;
            end
        end
        // settled levels after an idle stretch, both sides and the model
        if (i_fill_check) begin
            w_errors += report_mismatch("o_wstatus.fill", i_fill_expect, w_fill);
            w_errors += report_mismatch("o_rstatus.fill", i_fill_expect, int'(i_rstatus.fill));
            w_errors += report_mismatch("model queue length", i_fill_expect,
                                        sent.size() - r_count);
        end
    end

    // **********************************************************************
    // read domain
    // **********************************************************************

    always @(posedge i_rclk) begin
        r_fill = int'(i_rstatus.fill);
        if (!i_rrstn || r_was_reset) begin
            r_errors += report_mismatch("o_rvalid", 0, int'(i_rvalid));
            r_errors += report_mismatch("o_rstatus.empty", 1, int'(i_rstatus.empty));
            r_errors += report_mismatch("o_rstatus.fill", 0, r_fill);
        end
        r_was_reset = !i_rrstn;
        r_errors += report_mismatch("o_rstatus.empty", int'(r_fill == 0),
                                    int'(i_rstatus.empty));
        r_errors += report_mismatch("o_rstatus.almost_empty",
                                    int'(r_fill <= ALMOST_EMPTY_OFFSET),
                                    int'(i_rstatus.almost_empty));
        r_errors += report_mismatch("o_rvalid", int'(!i_rstatus.empty), int'(i_rvalid));
        // head of the model must sit on o_rdata when a read is taken
        if (i_rrstn && i_rvalid && i_rready) begin
            if (r_count >= sent.size()) begin
                $display("read accepted at %0t ns with no write left to match it", $time);
                r_errors++;
            end else begin
                r_errors += report_mismatch("o_rdata", int'(sent[r_count]), int'(i_rdata));
                r_count++;
            end
        end
    end

endmodule

// File: test/tb_afifo.sv
`timescale 1ns/1ns

module tb_afifo;

    import afifo_pkg::*;

    typedef enum {CMD_WRITE, CMD_READ, CMD_BOTH, CMD_IDLE} cmd_e;

    logic       wclk;
    logic       rclk;
    logic       wrstn;
    logic       rrstn;
    logic       wvalid;
    data_t      wdata;
    logic       wready;
    wr_status_t wstatus;
    logic       rready;
    logic       rvalid;
    data_t      rdata;
    rd_status_t rstatus;

    // settled fill request towards the checker
    logic       fill_check;
    int         fill_expect;
    int         wr_errors;
    int         rd_errors;

    // parsed stimulus with one entry per command line
    cmd_e        cmd_q[$];
    int          count_q[$];
    int          expect_q[$];
    logic        stim_ok;
    int unsigned lcg_state = 71190;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    tb_clkgen #(.HALF_PERIOD(50)) u_wclk_gen (.o_clk(wclk));
    tb_clkgen #(.HALF_PERIOD(65)) u_rclk_gen (.o_clk(rclk));

    afifo u_afifo (
        .i_wclk    (wclk),
        .i_wrstn   (wrstn),
        .i_wvalid  (wvalid),
        .i_wdata   (wdata),
        .o_wready  (wready),
        .o_wstatus (wstatus),
        .i_rclk    (rclk),
        .i_rrstn   (rrstn),
        .i_rready  (rready),
        .o_rvalid  (rvalid),
        .o_rdata   (rdata),
        .o_rstatus (rstatus)
    );

    tb_afifo_checker u_checker (
        .i_wclk        (wclk),
        .i_wrstn       (wrstn),
        .i_wvalid      (wvalid),
        .i_wdata       (wdata),
        .i_wready      (wready),
        .i_wstatus     (wstatus),
        .i_rclk        (rclk),
        .i_rrstn       (rrstn),
        .i_rready      (rready),
        .i_rvalid      (rvalid),
        .i_rdata       (rdata),
        .i_rstatus     (rstatus),
        .i_fill_check  (fill_check),
        .i_fill_expect (fill_expect),
        .o_wr_errors   (wr_errors),
        .o_rd_errors   (rd_errors)
    );

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // **********************************************************************
    // stimulus file
    // **********************************************************************

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    count;
        int    expect_v;
        int    total;
        string line;
        string word;
        fd = $fopen("test/afifo_stimulus.txt", "r");
        stim_ok = (fd != 0);
        total = 0;
        while (stim_ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %d", word, count, expect_v);
                if (n == 3) begin
                    if (word == "WRITE") begin
                        cmd_q.push_back(CMD_WRITE);
                    end else if (word == "READ") begin
                        cmd_q.push_back(CMD_READ);
                    end else if (word == "BOTH") begin
                        cmd_q.push_back(CMD_BOTH);
                    end else if (word == "IDLE") begin
                        cmd_q.push_back(CMD_IDLE);
                    end else begin
                        $display("unknown command %s in the stimulus file", word);
                        stim_ok = 1'b0;
                    end
                    count_q.push_back(count);
                    expect_q.push_back(expect_v);
                    total += count;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycle_limit = 4 * total + 50;
    endtask

    // **********************************************************************
    // drivers
    // **********************************************************************

    task automatic apply_reset();
        #1;
        wrstn <= 1'b0;
        rrstn <= 1'b0;
        // each side holds its reset for 3 cycles of its own clock
        fork
            begin
                repeat (3) @(posedge wclk);
                wrstn <= 1'b1;
            end
            begin
                repeat (3) @(posedge rclk);
                rrstn <= 1'b1;
            end
        join
    endtask

    // new data only once the offer in flight was taken
    task automatic write_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge wclk);
            if (!wvalid || wready) begin
                lcg_state = lcg_next(lcg_state);
                wdata <= data_t'(lcg_state >> 16);
            end
            wvalid <= 1'b1;
        end
        @(posedge wclk);
        wvalid <= 1'b0;
    endtask

    task automatic read_cycles(input int n);
        repeat (n) begin
            @(posedge rclk);
            rready <= 1'b1;
        end
        @(posedge rclk);
        rready <= 1'b0;
    endtask

    task automatic idle_and_check(input int n, input int k);
        repeat (n) @(posedge wclk);
        @(posedge wclk);
        fill_check  <= 1'b1;
        fill_expect <= k;
        @(posedge wclk);
        fill_check  <= 1'b0;
    endtask

    task automatic run_command(input cmd_e cmd, input int n, input int k);
        case (cmd)
            CMD_WRITE: write_cycles(n);
            CMD_READ:  read_cycles(n);
            CMD_BOTH: begin
                fork
                    write_cycles(n);
                    read_cycles(n);
                join
            end
            CMD_IDLE:  idle_and_check(n, k);
            default:   ;
        endcase
    endtask

    // **********************************************************************
    // run control
    // **********************************************************************

    always @(posedge wclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d write clock cycles, stimulus did not finish",
                     cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        wrstn       <= 1'b1;
        rrstn       <= 1'b1;
        wvalid      <= 1'b0;
        wdata       <= '0;
        rready      <= 1'b0;
        fill_check  <= 1'b0;
        fill_expect <= 0;
        load_stimulus();
        if (!stim_ok) begin
            $display("stimulus file test/afifo_stimulus.txt could not be read");
            $display("Verification failed");
            $finish;
        end else begin
            apply_reset();
            foreach (cmd_q[i]) begin
                run_command(cmd_q[i], count_q[i], expect_q[i]);
            end
            // falling edge, so the checker is done with the last rising edge
            @(negedge wclk);
            $display("error count: write side %0d, read side %0d", wr_errors, rd_errors);
            if (wr_errors == 0 && rd_errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

// File: test/afifo_stimulus.txt
# columns: command count expected
# WRITE, READ and BOTH count attempts in cycles of their own clock, expected unused
# IDLE waits count write clock cycles, then both fill levels must equal expected
IDLE   10   0
WRITE   5   0
IDLE   10   5
READ    2   0
IDLE   10   3
WRITE  20   0
IDLE   10  16
READ    6   0
IDLE   10  10
WRITE   3   0
IDLE   10  13
READ   20   0
IDLE   10   0
BOTH   30   0
READ   20   0
IDLE   10   0
WRITE  20   0
IDLE   10  16
BOTH   40   0
READ   40   0
IDLE   10   0
WRITE  16   0
IDLE   10  16
READ   16   0
IDLE   10   0

// File: verilog.f
rtl/afifo_pkg.sv
rtl/afifo_mem.sv
rtl/afifo_wr_ctrl.sv
rtl/afifo_rd_ctrl.sv
rtl/afifo.sv
test/tb_clkgen.sv
test/afifo_asserts.sv
test/tb_afifo_checker.sv
test/tb_afifo.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_afifo
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
STIMULUS  := test/afifo_stimulus.txt
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN) $(STIMULUS)
	./$(SIM_BIN) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	grep -q "^Verification passed$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
